// File: hw/serial_div_pkg.sv
// Shared definitions of the serial divider
// Widths, step count, operation and state encodings

`default_nettype none

package serial_div_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // Operand and result width
  localparam int unsigned DATA_W = 32;
  // Bit-step counter width
  localparam int unsigned CNT_W  = 5;

  // Counter start value, one less than the number of quotient bits
  localparam logic [CNT_W-1:0] DIV_STEPS_LAST = 5'd31;

  ////////////////////
  // Encodings
  ////////////////////

  // RISC-V M-extension divide operations
  typedef enum logic [1:0] {
    DIV_OP_DIV  = 2'b00,
    DIV_OP_DIVU = 2'b01,
    DIV_OP_REM  = 2'b10,
    DIV_OP_REMU = 2'b11
  } div_op_e;

  // Long-division FSM
  typedef enum logic [2:0] {
    DIV_IDLE, DIV_ABS_A, DIV_ABS_B, DIV_COMP, DIV_LAST, DIV_CHANGE_SIGN, DIV_FINISH
  } div_state_e;

endpackage

`default_nettype wire

// File: hw/div_cfg_regs.sv
// Divider configuration and request latch
// Holds the data-independent-timing bit and captures operands per request

`timescale 1ns/1ps
`default_nettype none

module div_cfg_regs (
  input  wire logic                             clk_i,
  input  wire logic                             rst_ni,
  input  wire logic                             cfg_we_i,
  input  wire logic                             cfg_dit_i,
  input  wire logic                             start_i,
  input  wire serial_div_pkg::div_op_e          op_i,
  input  wire logic [serial_div_pkg::DATA_W-1:0] op_a_i,
  input  wire logic [serial_div_pkg::DATA_W-1:0] op_b_i,
  output logic                                  dit_en_o,
  output logic [serial_div_pkg::DATA_W-1:0]     num_op_o,
  output logic [serial_div_pkg::DATA_W-1:0]     den_op_o,
  output logic                                  is_div_o,
  output logic                                  sign_a_o,
  output logic                                  sign_b_o
);

  import serial_div_pkg::*;

  logic              dit_q;
  div_op_e           op_q;
  logic [DATA_W-1:0] op_a_q;
  logic [DATA_W-1:0] op_b_q;
  logic              signed_op;

  // Config bit, written on any edge with the write enable
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dit_q <= 1'b0;
    end else if (cfg_we_i) begin
      dit_q <= cfg_dit_i;
    end
  end

  // Operation held for the whole request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      op_q <= DIV_OP_DIV;
    end else if (start_i) begin
      op_q <= op_i;
    end
  end

  // Operand payload
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      op_a_q <= op_a_i;
      op_b_q <= op_b_i;
    end
  end

  ////////////////////
  // Decode
  ////////////////////

  always_comb begin
    unique case (op_q)
      DIV_OP_DIV:  begin is_div_o = 1'b1; signed_op = 1'b1; end
      DIV_OP_DIVU: begin is_div_o = 1'b1; signed_op = 1'b0; end
      DIV_OP_REM:  begin is_div_o = 1'b0; signed_op = 1'b1; end
      default:     begin is_div_o = 1'b0; signed_op = 1'b0; end
    endcase
  end

  // Sign only counts for signed ops
  assign sign_a_o = op_a_q[DATA_W-1] & signed_op;
  assign sign_b_o = op_b_q[DATA_W-1] & signed_op;

  assign num_op_o = op_a_q;
  assign den_op_o = op_b_q;
  assign dit_en_o = dit_q;

endmodule

`default_nettype wire

// File: hw/div_ctrl.sv
// Divider control
// Seven-state long-division FSM, bit-step counter and req/ack handshake

`timescale 1ns/1ps
`default_nettype none

module div_ctrl (
  input  wire logic                            clk_i,
  input  wire logic                            rst_ni,
  input  wire logic                            req_i,
  input  wire logic                            dit_en_i,
  input  wire logic                            den_zero_i,
  output logic                                 start_o,
  output serial_div_pkg::div_state_e           state_o,
  output logic [serial_div_pkg::CNT_W-1:0]     count_o,
  output logic                                 ack_o
);

  import serial_div_pkg::*;

  div_state_e       state_q, state_d;
  logic [CNT_W-1:0] count_q, count_d;
  logic             ack_q, ack_d;
  logic             early_exit;

  // New request only accepted from IDLE
  assign start_o = (state_q == DIV_IDLE) & req_i;

  // Zero divisor skips the iterations unless timing must not leak it
  assign early_exit = (state_q == DIV_ABS_A) & den_zero_i & ~dit_en_i;

  ////////////////////
  // Next state
  ////////////////////

  always_comb begin
    state_d = state_q;
    count_d = count_q;

    unique case (state_q)
      DIV_IDLE: begin
        if (req_i) begin
          state_d = DIV_ABS_A;
        end
      end

      DIV_ABS_A: begin
        state_d = early_exit ? DIV_FINISH : DIV_ABS_B;
      end

      // Arm counter for the first compare step
      DIV_ABS_B: begin
        state_d = DIV_COMP;
        count_d = DIV_STEPS_LAST;
      end

      // Count 1 is the last COMP step, bit 0 is done in LAST
      DIV_COMP: begin
        count_d = count_q - 1'b1;
        if (count_q == CNT_W'(1)) begin
          state_d = DIV_LAST;
        end
      end

      DIV_LAST: begin
        state_d = DIV_CHANGE_SIGN;
      end

      DIV_CHANGE_SIGN: begin
        state_d = DIV_FINISH;
      end

      // Hold result until requester drops req
      DIV_FINISH: begin
        if (!req_i) begin
          state_d = DIV_IDLE;
        end
      end

      default: begin
        state_d = DIV_IDLE;
      end
    endcase
  end

  // Ack follows FINISH one edge later
  // Early exit raises it on the jump itself
  assign ack_d = early_exit | ((state_q == DIV_FINISH) & req_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= DIV_IDLE;
      count_q <= '0;
      ack_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      count_q <= count_d;
      ack_q   <= ack_d;
    end
  end

  assign state_o = state_q;
  assign count_o = count_q;
  assign ack_o   = ack_q;

endmodule

`default_nettype wire

// File: hw/div_datapath.sv
// Divider datapath
// Restoring long division on absolute values with a single shared subtractor,
// followed by RISC-V sign correction of the quotient or remainder

`timescale 1ns/1ps
`default_nettype none

module div_datapath (
  input  wire logic                             clk_i,
  input  wire logic                             rst_ni,
  input  wire serial_div_pkg::div_state_e       state_i,
  input  wire logic [serial_div_pkg::CNT_W-1:0]  count_i,
  input  wire logic [serial_div_pkg::DATA_W-1:0] num_op_i,
  input  wire logic [serial_div_pkg::DATA_W-1:0] den_op_i,
  input  wire logic                             is_div_i,
  input  wire logic                             sign_a_i,
  input  wire logic                             sign_b_i,
  output logic                                  den_zero_o,
  output logic [serial_div_pkg::DATA_W-1:0]     result_o
);

  import serial_div_pkg::*;

  logic [DATA_W-1:0] num_q, num_d;
  logic [DATA_W-1:0] den_q, den_d;
  logic [DATA_W-1:0] quo_q, quo_d;
  logic [DATA_W-1:0] rem_q, rem_d;
  logic              div_zero_q, div_zero_d;
  logic [DATA_W-1:0] add_a, add_b;
  logic [DATA_W:0]   add_res;
  logic              is_ge;
  logic [DATA_W-1:0] one_shift;
  logic [DATA_W-1:0] next_rem;
  logic [DATA_W-1:0] next_quo;
  logic [CNT_W-1:0]  bit_idx;
  logic              change_sign;

  assign den_zero_o = (den_op_i == '0);

  ////////////////////
  // Shared adder
  ////////////////////

  // Operand choice per state, default is 0 - numerator
  always_comb begin
    add_a = '0;
    add_b = num_op_i;
    unique case (state_i)
      DIV_ABS_B:        add_b = den_op_i;
      DIV_COMP,
      DIV_LAST: begin
        add_a = rem_q;
        add_b = den_q;
      end
      DIV_CHANGE_SIGN:  add_b = rem_q;
      default:          add_b = num_op_i;
    endcase
  end

  // A - B with borrow out in the top bit
  assign add_res = {1'b0, add_a} + {1'b1, ~add_b} + {{DATA_W{1'b0}}, 1'b1};

  // Both sides unsigned here, no borrow means remainder >= divisor
  assign is_ge = ~add_res[DATA_W];

  assign one_shift = {{(DATA_W-1){1'b0}}, 1'b1} << count_i;
  assign next_rem  = is_ge ? add_res[DATA_W-1:0] : rem_q;
  assign next_quo  = is_ge ? (quo_q | one_shift) : quo_q;
  // Next numerator bit to bring down
  assign bit_idx   = count_i - 1'b1;

  // Quotient sign flip is skipped for a zero divisor
  assign change_sign = is_div_i ? ((sign_a_i ^ sign_b_i) & ~div_zero_q) : sign_a_i;

  ////////////////////
  // Step logic
  ////////////////////

  always_comb begin
    num_d      = num_q;
    den_d      = den_q;
    quo_d      = quo_q;
    rem_d      = rem_q;
    div_zero_d = div_zero_q;

    unique case (state_i)
      // Preload the zero-divisor answer for the early exit
      DIV_ABS_A: begin
        num_d      = sign_a_i ? add_res[DATA_W-1:0] : num_op_i;
        quo_d      = '0;
        rem_d      = is_div_i ? '1 : num_op_i;
        div_zero_d = den_zero_o;
      end

      // Partial remainder starts with the numerator MSB
      DIV_ABS_B: begin
        den_d = sign_b_i ? add_res[DATA_W-1:0] : den_op_i;
        rem_d = {{(DATA_W-1){1'b0}}, num_q[DATA_W-1]};
      end

      // next_rem < divisor, so its MSB is always clear
      DIV_COMP: begin
        rem_d = {next_rem[DATA_W-2:0], num_q[bit_idx]};
        quo_d = next_quo;
      end

      // Bit 0, remainder register now carries the answer
      DIV_LAST: begin
        rem_d = is_div_i ? next_quo : next_rem;
      end

      DIV_CHANGE_SIGN: begin
        rem_d = change_sign ? add_res[DATA_W-1:0] : rem_q;
      end

      default: begin
        rem_d = rem_q;
      end
    endcase
  end

  // Result and flag
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rem_q      <= '0;
      div_zero_q <= 1'b0;
    end else begin
      rem_q      <= rem_d;
      div_zero_q <= div_zero_d;
    end
  end

  // Working operands
  always_ff @(posedge clk_i) begin
    num_q <= num_d;
    den_q <= den_d;
    quo_q <= quo_d;
  end

  assign result_o = rem_q;

endmodule

`default_nettype wire

// File: hw/serial_div_top.sv
// Serial 32-bit integer divider
// DIV, DIVU, REM and REMU behind a four-phase req/ack handshake

`timescale 1ns/1ps
`default_nettype none

module serial_div_top (
  input  wire logic                             clk_i,
  input  wire logic                             rst_ni,
  input  wire logic                             req_i,
  input  wire serial_div_pkg::div_op_e          op_i,
  input  wire logic [serial_div_pkg::DATA_W-1:0] op_a_i,
  input  wire logic [serial_div_pkg::DATA_W-1:0] op_b_i,
  input  wire logic                             cfg_we_i,
  input  wire logic                             cfg_dit_i,
  output logic                                  ack_o,
  output logic [serial_div_pkg::DATA_W-1:0]     result_o
);

  import serial_div_pkg::*;

  logic              start;
  div_state_e        state;
  logic [CNT_W-1:0]  count;
  logic              dit_en;
  logic              den_zero;
  logic [DATA_W-1:0] num_op;
  logic [DATA_W-1:0] den_op;
  logic              is_div;
  logic              sign_a;
  logic              sign_b;

  ////////////////////
  // Request latch
  ////////////////////

  div_cfg_regs div_cfg_regs_inst (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .cfg_we_i  (cfg_we_i),
    .cfg_dit_i (cfg_dit_i),
    .start_i   (start),
    .op_i      (op_i),
    .op_a_i    (op_a_i),
    .op_b_i    (op_b_i),
    .dit_en_o  (dit_en),
    .num_op_o  (num_op),
    .den_op_o  (den_op),
    .is_div_o  (is_div),
    .sign_a_o  (sign_a),
    .sign_b_o  (sign_b)
  );

  // FSM and handshake
  div_ctrl div_ctrl_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (req_i),
    .dit_en_i   (dit_en),
    .den_zero_i (den_zero),
    .start_o    (start),
    .state_o    (state),
    .count_o    (count),
    .ack_o      (ack_o)
  );

  ////////////////////
  // Datapath
  ////////////////////

  div_datapath div_datapath_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .state_i    (state),
    .count_i    (count),
    .num_op_i   (num_op),
    .den_op_i   (den_op),
    .is_div_i   (is_div),
    .sign_a_i   (sign_a),
    .sign_b_i   (sign_b),
    .den_zero_o (den_zero),
    .result_o   (result_o)
  );

endmodule

`default_nettype wire

// File: verif/serial_div_tb.sv
// Testbench for the serial divider
// Random and corner-case DIV/DIVU/REM/REMU requests over the req/ack handshake,
// checked against a reference model with latency and hold checks

`timescale 1ns/1ps
`default_nettype none

module serial_div_tb;

  import serial_div_pkg::*;

  // Cycles allowed for ack to rise and to fall
  localparam int unsigned ACK_TIMEOUT  = 60;
  localparam int unsigned DROP_TIMEOUT = 4;
  localparam int unsigned NUM_RANDOM   = 200;

  logic              clk;
  logic              rst_n;
  logic              req;
  div_op_e           op;
  logic [DATA_W-1:0] op_a;
  logic [DATA_W-1:0] op_b;
  logic              cfg_we;
  logic              cfg_dit;
  logic              ack;
  logic [DATA_W-1:0] result;

  // Shared between stimulus and checker
  logic [DATA_W-1:0] exp_result;
  logic [DATA_W-1:0] held_result;
  string             test_name;
  logic              ack_seen;
  logic              dit_mode;
  int unsigned       checks_done;
  int unsigned       ops_issued;
  int unsigned       seed_val;

  serial_div_top serial_div_top_inst (
    .clk_i     (clk),
    .rst_ni    (rst_n),
    .req_i     (req),
    .op_i      (op),
    .op_a_i    (op_a),
    .op_b_i    (op_b),
    .cfg_we_i  (cfg_we),
    .cfg_dit_i (cfg_dit),
    .ack_o     (ack),
    .result_o  (result)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////
  // Reporting
  ////////////////////

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [DATA_W-1:0] expected,
                                 input logic [DATA_W-1:0] actual);
    $display("** Error [%s]: expected 0x%08h, actual 0x%08h", name, expected, actual);
    stop_run("Result mismatch");
  endtask

  ////////////////////
  // Reference model
  ////////////////////

  // RISC-V M-extension divide and remainder rules
  function automatic logic [DATA_W-1:0] ref_div(input div_op_e o,
                                                input logic [DATA_W-1:0] a,
                                                input logic [DATA_W-1:0] b);
    logic signed [DATA_W-1:0] sa;
    logic signed [DATA_W-1:0] sb;
    logic                     overflow;
    logic [DATA_W-1:0]        res;
    sa = a;
    sb = b;
    overflow = (a == {1'b1, {(DATA_W-1){1'b0}}}) && (b == '1);
    case (o)
      DIV_OP_DIV: begin
        if (b == '0) res = '1;
        else if (overflow) res = a;
        else res = sa / sb;
      end
      DIV_OP_DIVU: begin
        if (b == '0) res = '1;
        else res = a / b;
      end
      // Remainder keeps the dividend's sign
      DIV_OP_REM: begin
        if (b == '0) res = a;
        else if (overflow) res = '0;
        else res = sa % sb;
      end
      default: begin
        if (b == '0) res = a;
        else res = a % b;
      end
    endcase
    return res;
  endfunction

  ////////////////////
  // Checker
  ////////////////////

  // Compare on ack rise, then hold result steady while ack stays high
  always @(negedge clk) begin
    if (!rst_n) begin
      ack_seen = 1'b0;
    end else if (ack && !ack_seen) begin
      ack_seen    = 1'b1;
      held_result = result;
      checks_done = checks_done + 1;
      assert (result == exp_result) else report_mismatch(test_name, exp_result, result);
    end else if (ack) begin
      assert (result == held_result)
        else report_mismatch({test_name, " hold"}, held_result, result);
    end else begin
      ack_seen = 1'b0;
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic set_dit(input logic value);
    @(negedge clk);
    cfg_we  = 1'b1;
    cfg_dit = value;
    @(negedge clk);
    cfg_we   = 1'b0;
    dit_mode = value;
  endtask

  // One full four-phase transfer with latency check
  task automatic run_op(input string name, input div_op_e o, input logic [DATA_W-1:0] a,
                        input logic [DATA_W-1:0] b);
    int unsigned edges;
    int unsigned exp_lat;
    int unsigned hold;
    exp_lat    = (b == '0 && !dit_mode) ? 1 : 36;
    hold       = $urandom % 4;
    exp_result = ref_div(o, a, b);
    test_name  = name;
    ops_issued = ops_issued + 1;
    @(negedge clk);
    op   = o;
    op_a = a;
    op_b = b;
    req  = 1'b1;
    edges = 0;
    while (!ack && edges <= ACK_TIMEOUT) begin
      @(negedge clk);
      edges = edges + 1;
    end
    if (!ack) begin
      stop_run($sformatf("Timeout: no ack for %s within %0d cycles", name, ACK_TIMEOUT));
    end
    // First edge after raising req is the one that samples it
    assert (edges - 1 == exp_lat) else begin
      $display("** Error [%s latency]: expected %0d, actual %0d", name, exp_lat, edges - 1);
      stop_run("Wrong ack latency");
    end
    repeat (hold) begin
      @(negedge clk);
      assert (ack) else stop_run($sformatf("ack fell while req was still high in %s", name));
    end
    req = 1'b0;
    edges = 0;
    while (ack && edges <= DROP_TIMEOUT) begin
      @(negedge clk);
      edges = edges + 1;
    end
    if (ack) begin
      stop_run($sformatf("Timeout: ack stayed high after req fell in %s", name));
    end
  endtask

  // Mix of plain random values and edge values
  function automatic logic [DATA_W-1:0] rand_operand();
    logic [DATA_W-1:0] v;
    case ($urandom % 10)
      0:       v = $urandom % 16;
      1:       v = -($urandom % 16);
      2:       v = {1'b1, {(DATA_W-1){1'b0}}};
      3:       v = '1;
      4:       v = '0;
      default: v = $urandom;
    endcase
    return v;
  endfunction

  initial begin
    rst_n       = 1'b0;
    req         = 1'b0;
    op          = DIV_OP_DIV;
    op_a        = '0;
    op_b        = '0;
    cfg_we      = 1'b0;
    cfg_dit     = 1'b0;
    dit_mode    = 1'b0;
    exp_result  = '0;
    held_result = '0;
    test_name   = "reset";
    checks_done = 0;
    ops_issued  = 0;
    seed_val    = $urandom(30589);

    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    assert (ack == 1'b0) else stop_run("ack is high after reset");
    assert (result == '0) else report_mismatch("reset result", '0, result);

    // Zero divisor, early exit
    run_op("div by zero", DIV_OP_DIV, 32'h1234_5678, '0);
    run_op("divu by zero", DIV_OP_DIVU, 32'h8765_4321, '0);
    run_op("rem by zero", DIV_OP_REM, 32'h8765_4321, '0);
    run_op("remu by zero", DIV_OP_REMU, 32'h1234_5678, '0);
    // Signed overflow
    run_op("div min by -1", DIV_OP_DIV, 32'h8000_0000, '1);
    run_op("rem min by -1", DIV_OP_REM, 32'h8000_0000, '1);
    // Mixed signs
    run_op("div neg by pos", DIV_OP_DIV, -32'sd7, 32'd2);
    run_op("rem neg by pos", DIV_OP_REM, -32'sd7, 32'd2);
    run_op("div pos by neg", DIV_OP_DIV, 32'd100, -32'sd9);
    run_op("rem pos by neg", DIV_OP_REM, 32'd100, -32'sd9);
    // Operand equal to divisor
    run_op("div equal", DIV_OP_DIV, -32'sd12345, -32'sd12345);
    run_op("divu equal", DIV_OP_DIVU, 32'hFFFF_FFF0, 32'hFFFF_FFF0);
    run_op("rem equal", DIV_OP_REM, 32'd77, 32'd77);
    run_op("remu equal", DIV_OP_REMU, 32'h8000_0001, 32'h8000_0001);
    run_op("divu large", DIV_OP_DIVU, 32'hFFFF_FFFF, 32'h0000_0003);

    // Data-independent timing hides the zero divisor
    // Negative dividend, quotient sign fix must stay off
    set_dit(1'b1);
    run_op("dit div by zero", DIV_OP_DIV, 32'h8765_4321, '0);
    run_op("dit divu by zero", DIV_OP_DIVU, 32'h8765_4321, '0);
    run_op("dit rem by zero", DIV_OP_REM, 32'h8765_4321, '0);
    run_op("dit remu by zero", DIV_OP_REMU, 32'h1234_5678, '0);
    run_op("dit normal", DIV_OP_DIV, 32'd1000, 32'd7);
    set_dit(1'b0);

    for (int i = 0; i < NUM_RANDOM; i++) begin
      run_op($sformatf("random %0d", i), div_op_e'($urandom % 4), rand_operand(),
             rand_operand());
    end

    @(negedge clk);
    assert (checks_done == ops_issued) else begin
      $display("** Error [check count]: expected %0d, actual %0d", ops_issued, checks_done);
      stop_run("Not every request was checked");
    end
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

// File: serial_div.f
hw/serial_div_pkg.sv
hw/div_cfg_regs.sv
hw/div_ctrl.sv
hw/div_datapath.sv
hw/serial_div_top.sv
verif/serial_div_tb.sv

// File: Makefile
# Verilator build and run of the serial divider testbench

SIM := obj_dir/serial_div_sim
LOG := sim.log

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): serial_div.f hw/*.sv verif/*.sv
	verilator --binary --timing --assert -Wno-fatal \
	  -f serial_div.f --top-module serial_div_tb \
	  -Mdir obj_dir -o serial_div_sim

# Pass only if the log holds the pass line
run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q '\*\* PASS \*\*' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
